//--- hw/playseq_defs.svh
/*
 * PlaySeq timing and sequence constants
 * all times are short cycle counts
 */
`ifndef PLAYSEQ_DEFS_SVH
`define PLAYSEQ_DEFS_SVH

`define PLAYSEQ_SEQ_LEN       8    // steps in every sequence
`define PLAYSEQ_SHOW_CYCLES   8    // led lit per preview step
`define PLAYSEQ_GAP_CYCLES    4    // dark between preview steps
`define PLAYSEQ_TIMEOUT_BASE  32   // limit at level 3, doubles per level down

`define PLAYSEQ_START_LEN0    2
`define PLAYSEQ_START_LEN1    3
`define PLAYSEQ_START_LEN2    4
`define PLAYSEQ_START_LEN3    6

`endif

//--- hw/playseq_pkg.sv
/*
 * PlaySeq shared types, game states and the fixed sequence table
 */
`default_nettype none
`include "playseq_defs.svh"

package playseq_pkg;

    typedef logic [3:0] step_t;     // button / led code
    typedef logic [2:0] addr_t;     // step index
    typedef logic [3:0] len_t;      // round length 1..8
    typedef logic [1:0] level_t;
    typedef logic [1:0] seq_sel_t;
    typedef logic [3:0] score_t;    // saturates at 15
    typedef logic [8:0] timer_t;

    typedef enum logic [3:0] {
        IDLE, WRITE, LOAD, SHOW, GAP, PLAY, CHECK, GROW, WIN, LOSS
    } game_state_t;

    // three fixed one-hot sequences, the fourth lives in ram
    localparam step_t SEQ_TABLE [3][`PLAYSEQ_SEQ_LEN] = '{
        '{4'h1, 4'h2, 4'h4, 4'h8, 4'h8, 4'h4, 4'h2, 4'h1},
        '{4'h4, 4'h1, 4'h8, 4'h2, 4'h1, 4'h4, 4'h2, 4'h8},
        '{4'h2, 4'h2, 4'h8, 4'h1, 4'h4, 4'h8, 4'h1, 4'h4}
    };

endpackage

`default_nettype wire

//--- hw/playseq_ctrl_if.sv
/*
 * PlaySeq control / datapath link
 * one-cycle command levels one way, status back the other
 */
`timescale 1ns/1ps
`default_nettype none

interface playseq_ctrl_if;
    import playseq_pkg::*;

    // commands from control
    logic  clear_step, next_step;
    logic  load_len, grow_len;
    logic  clear_timer, run_timer;
    logic  clear_led, run_led;
    logic  ram_write;
    logic  show;        // leds display current step

    // status from datapath
    step_t step_data;
    logic  match, step_last, len_full, ram_last;
    logic  timed_out, show_done, gap_done;

    modport control (
        output clear_step, next_step, load_len, grow_len,
               clear_timer, run_timer, clear_led, run_led, ram_write, show,
        input  step_data, match, step_last, len_full, ram_last,
               timed_out, show_done, gap_done
    );

    modport datapath (
        input  clear_step, next_step, load_len, grow_len,
               clear_timer, run_timer, clear_led, run_led, ram_write,
        output step_data, match, step_last, len_full, ram_last,
               timed_out, show_done, gap_done
    );

endinterface

`default_nettype wire

//--- hw/playseq_input.sv
/*
 * PlaySeq input side
 * button synchronizer and single press pulse per press
 */
`timescale 1ns/1ps
`default_nettype none

module playseq_input (
    input  logic               clock,
    input  logic               reset,
    input  playseq_pkg::step_t buttons,
    output logic               press_valid,
    output playseq_pkg::step_t press_code
);
    import playseq_pkg::*;

    step_t sync1, sync2;
    logic  held;        // a press is in progress, wait for release

    always_ff @(posedge clock) begin
        if (reset) begin
            sync1       <= '0;
            sync2       <= '0;
            held        <= 1'b0;
            press_valid <= 1'b0;
            press_code  <= '0;
        end else begin
            sync1       <= buttons;
            sync2       <= sync1;
            press_code  <= sync2;           // equals the code at the pulse, drops on release
            press_valid <= 1'b0;
            if (|sync2 && !held) begin
                press_valid <= 1'b1;
                held        <= 1'b1;
            end else if (!(|sync2)) begin
                held <= 1'b0;               // all released
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/playseq_datapath.sv
/*
 * PlaySeq datapath
 * step/length counters, sequence source, custom ram, compare and timers
 */
`timescale 1ns/1ps
`default_nettype none
`include "playseq_defs.svh"

module playseq_datapath (
    input  logic                  clock,
    input  logic                  reset,
    input  playseq_pkg::level_t   level,
    input  playseq_pkg::seq_sel_t seq_sel,
    input  logic                  press_valid,
    input  playseq_pkg::step_t    press_code,
    playseq_ctrl_if.datapath      ctrl
);
    import playseq_pkg::*;

    addr_t  step_q;
    len_t   len_q;
    timer_t timer_q;            // timeout count
    timer_t led_q;              // show / gap count
    step_t  press_q;            // last press, judged in CHECK
    step_t  ram [`PLAYSEQ_SEQ_LEN];
    timer_t limit;
    len_t   start_len;

    // ------------------------------------------------------------------------
    // level decode
    // ------------------------------------------------------------------------
    assign limit = timer_t'(`PLAYSEQ_TIMEOUT_BASE) << (2'd3 - level);

    always_comb begin
        case (level)
            2'd0:    start_len = len_t'(`PLAYSEQ_START_LEN0);
            2'd1:    start_len = len_t'(`PLAYSEQ_START_LEN1);
            2'd2:    start_len = len_t'(`PLAYSEQ_START_LEN2);
            default: start_len = len_t'(`PLAYSEQ_START_LEN3);
        endcase
    end

    // ------------------------------------------------------------------------
    // counters and timers
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            step_q  <= '0;
            len_q   <= '0;
            timer_q <= '0;
            led_q   <= '0;
            press_q <= '0;
            for (int i = 0; i < `PLAYSEQ_SEQ_LEN; i++)
                ram[i] <= '0;
        end else begin
            if (ctrl.clear_step)     step_q <= '0;
            else if (ctrl.next_step) step_q <= step_q + addr_t'(1);

            if (ctrl.load_len)      len_q <= start_len;
            else if (ctrl.grow_len) len_q <= len_q + len_t'(1);

            // hold at the limit instead of wrapping
            if (ctrl.clear_timer)                      timer_q <= '0;
            else if (ctrl.run_timer && !ctrl.timed_out) timer_q <= timer_q + timer_t'(1);

            if (ctrl.clear_led)    led_q <= '0;
            else if (ctrl.run_led) led_q <= led_q + timer_t'(1);

            if (press_valid)
                press_q <= press_code;

            if (ctrl.ram_write)
                ram[step_q] <= press_code;  // custom sequence entry
        end
    end

    // ------------------------------------------------------------------------
    // sequence source and status
    // ------------------------------------------------------------------------
    always_comb begin
        case (seq_sel)
            2'd0:    ctrl.step_data = SEQ_TABLE[0][step_q];
            2'd1:    ctrl.step_data = SEQ_TABLE[1][step_q];
            2'd2:    ctrl.step_data = SEQ_TABLE[2][step_q];
            default: ctrl.step_data = ram[step_q];
        endcase
    end

    assign ctrl.match     = (press_q == ctrl.step_data);
    assign ctrl.step_last = ({1'b0, step_q} == len_q - len_t'(1));
    assign ctrl.len_full  = (len_q == len_t'(`PLAYSEQ_SEQ_LEN));
    assign ctrl.ram_last  = (step_q == addr_t'(`PLAYSEQ_SEQ_LEN - 1));
    assign ctrl.timed_out = (timer_q >= limit - timer_t'(1));
    assign ctrl.show_done = (led_q == timer_t'(`PLAYSEQ_SHOW_CYCLES - 1));
    assign ctrl.gap_done  = (led_q == timer_t'(`PLAYSEQ_GAP_CYCLES - 1));

endmodule

`default_nettype wire

//--- hw/playseq_control.sv
/*
 * PlaySeq game FSM
 * setup, preview, play, judgement and custom sequence entry
 */
`timescale 1ns/1ps
`default_nettype none

module playseq_control (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  write_mode,
    input  playseq_pkg::seq_sel_t seq_sel,
    input  logic                  press_valid,
    playseq_ctrl_if.control       ctrl,
    output logic                  your_turn,
    output logic                  playing,
    output logic                  won,
    output logic                  lost
);
    import playseq_pkg::*;

    game_state_t state, state_next;

    always_ff @(posedge clock) begin
        if (reset) state <= IDLE;
        else       state <= state_next;
    end

    // ------------------------------------------------------------------------
    // next state and commands
    // ------------------------------------------------------------------------
    always_comb begin
        state_next       = state;
        ctrl.clear_step  = 1'b0;
        ctrl.next_step   = 1'b0;
        ctrl.load_len    = 1'b0;
        ctrl.grow_len    = 1'b0;
        ctrl.clear_timer = 1'b0;
        ctrl.run_timer   = 1'b0;
        ctrl.clear_led   = 1'b0;
        ctrl.run_led     = 1'b0;
        ctrl.ram_write   = 1'b0;
        ctrl.show        = 1'b0;

        case (state)
            IDLE: begin
                ctrl.clear_step = 1'b1;
                if (start) begin
                    // write_mode turns start into sequence entry
                    if (write_mode && seq_sel == 2'd3) state_next = WRITE;
                    else                               state_next = LOAD;
                end
            end
            WRITE: begin
                if (press_valid) begin
                    ctrl.ram_write = 1'b1;
                    ctrl.next_step = 1'b1;
                    if (ctrl.ram_last) state_next = IDLE;
                end
            end
            LOAD: begin
                ctrl.load_len   = 1'b1;
                ctrl.clear_step = 1'b1;
                ctrl.clear_led  = 1'b1;
                state_next      = SHOW;
            end
            SHOW: begin
                ctrl.show    = 1'b1;
                ctrl.run_led = 1'b1;
                if (ctrl.show_done) begin
                    ctrl.clear_led = 1'b1;
                    state_next     = GAP;
                end
            end
            GAP: begin
                ctrl.run_led = 1'b1;
                if (ctrl.gap_done) begin
                    ctrl.clear_led = 1'b1;
                    if (ctrl.step_last) begin
                        ctrl.clear_step  = 1'b1;     // replay from step 0
                        ctrl.clear_timer = 1'b1;
                        state_next       = PLAY;
                    end else begin
                        ctrl.next_step = 1'b1;
                        state_next     = SHOW;
                    end
                end
            end
            PLAY: begin
                ctrl.run_timer = 1'b1;
                if (press_valid) begin
                    ctrl.clear_timer = 1'b1;         // restart per press
                    state_next       = CHECK;
                end else if (ctrl.timed_out) begin
                    state_next = LOSS;
                end
            end
            CHECK: begin
                if (!ctrl.match)         state_next = LOSS;
                else if (!ctrl.step_last) begin
                    ctrl.next_step = 1'b1;
                    state_next     = PLAY;
                end
                else if (ctrl.len_full)  state_next = WIN;
                else                     state_next = GROW;
            end
            GROW: begin
                ctrl.grow_len   = 1'b1;
                ctrl.clear_step = 1'b1;
                ctrl.clear_led  = 1'b1;
                state_next      = SHOW;
            end
            WIN:     state_next = IDLE;
            LOSS:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign your_turn = (state == PLAY);
    assign playing   = (state != IDLE) && (state != WRITE);
    assign won       = (state == WIN);     // one cycle per game
    assign lost      = (state == LOSS);

endmodule

`default_nettype wire

//--- hw/playseq_output.sv
/*
 * PlaySeq output side
 * led drive from preview or press echo, win and loss counters
 */
`timescale 1ns/1ps
`default_nettype none

module playseq_output (
    input  logic                clock,
    input  logic                reset,
    input  logic                show,
    input  playseq_pkg::step_t  step_data,
    input  playseq_pkg::step_t  press_code,
    input  logic                press_valid,
    input  logic                won,
    input  logic                lost,
    output playseq_pkg::step_t  leds,
    output playseq_pkg::score_t wins,
    output playseq_pkg::score_t losses
);
    import playseq_pkg::*;

    step_t echo_q;
    logic  echo_on;     // press held, echo it

    always_ff @(posedge clock) begin
        if (reset) begin
            echo_on <= 1'b0;
            wins    <= '0;
            losses  <= '0;
        end else begin
            if (press_valid)            echo_on <= 1'b1;
            else if (press_code == '0)  echo_on <= 1'b0;

            if (won && wins != '1)     wins   <= wins + score_t'(1);
            if (lost && losses != '1)  losses <= losses + score_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (press_valid) echo_q <= press_code;
    end

    assign leds = show ? step_data : (echo_on ? echo_q : '0);

endmodule

`default_nettype wire

//--- hw/playseq_top.sv
/*
 * PlaySeq top level
 * input side, FSM with datapath, output side
 */
`timescale 1ns/1ps
`default_nettype none

module playseq_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  playseq_pkg::level_t   level,
    input  playseq_pkg::seq_sel_t seq_sel,
    input  logic                  write_mode,
    input  playseq_pkg::step_t    buttons,
    output playseq_pkg::step_t    leds,
    output logic                  your_turn,
    output logic                  playing,
    output playseq_pkg::score_t   wins,
    output playseq_pkg::score_t   losses
);
    import playseq_pkg::*;

    logic  press_valid;
    step_t press_code;
    logic  won, lost;

    playseq_ctrl_if ctrl ();

    playseq_input u_input (
        .clock       (clock),
        .reset       (reset),
        .buttons     (buttons),
        .press_valid (press_valid),
        .press_code  (press_code)
    );

    playseq_control u_control (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .write_mode  (write_mode),
        .seq_sel     (seq_sel),
        .press_valid (press_valid),
        .ctrl        (ctrl.control),
        .your_turn   (your_turn),
        .playing     (playing),
        .won         (won),
        .lost        (lost)
    );

    playseq_datapath u_datapath (
        .clock       (clock),
        .reset       (reset),
        .level       (level),
        .seq_sel     (seq_sel),
        .press_valid (press_valid),
        .press_code  (press_code),
        .ctrl        (ctrl.datapath)
    );

    playseq_output u_output (
        .clock       (clock),
        .reset       (reset),
        .show        (ctrl.show),
        .step_data   (ctrl.step_data),
        .press_code  (press_code),
        .press_valid (press_valid),
        .won         (won),
        .lost        (lost),
        .leds        (leds),
        .wins        (wins),
        .losses      (losses)
    );

endmodule

`default_nettype wire

//--- bench/tb_playseq.sv
/*
 * PlaySeq testbench
 * directed games checked against a model built from the sequence table
 */
`timescale 1ns/1ps
`default_nettype none
`include "playseq_defs.svh"

module tb_playseq;
    import playseq_pkg::*;

    // six games of up to 7 rounds, 96 preview and 64 press cycles per round, with margin
    localparam int MAX_CYCLES = 60000;

    logic     clock = 1'b0;
    logic     reset;
    logic     start;
    level_t   level;
    seq_sel_t seq_sel;
    logic     write_mode;
    step_t    buttons;
    step_t    leds;
    logic     your_turn;
    logic     playing;
    score_t   wins;
    score_t   losses;

    int    checks = 0;
    int    errors = 0;
    int    cycles = 0;
    int    exp_wins = 0;
    int    exp_losses = 0;
    step_t custom_seq [`PLAYSEQ_SEQ_LEN];   // codes written to the ram

    playseq_top dut (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .level      (level),
        .seq_sel    (seq_sel),
        .write_mode (write_mode),
        .buttons    (buttons),
        .leds       (leds),
        .your_turn  (your_turn),
        .playing    (playing),
        .wins       (wins),
        .losses     (losses)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped: cycle limit of %0d reached", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic step_t exp_step(input int s, input int i);
        if (s == 3) return custom_seq[3'(i)];
        else        return SEQ_TABLE[2'(s)][3'(i)];
    endfunction

    function automatic int start_len(input level_t lvl);
        case (lvl)
            2'd0:    return `PLAYSEQ_START_LEN0;
            2'd1:    return `PLAYSEQ_START_LEN1;
            2'd2:    return `PLAYSEQ_START_LEN2;
            default: return `PLAYSEQ_START_LEN3;
        endcase
    endfunction

    function automatic int timeout_limit(input level_t lvl);
        return `PLAYSEQ_TIMEOUT_BASE << (3 - int'(lvl));   // doubles per level down
    endfunction

    // ------------------------------------------------------------------------
    // checks and helpers
    // ------------------------------------------------------------------------
    task automatic expect_eq(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("mismatch %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before) $display("test %s: ok", name);
        else                      $display("test %s: %0d error(s)", name, errors - err_before);
    endtask

    task automatic press(input step_t code);
        @(posedge clock);
        buttons <= code;
        repeat (4) @(posedge clock);
        buttons <= '0;
        repeat (4) @(posedge clock);
    endtask

    task automatic start_game(input int s, input level_t lvl, input logic wm);
        @(posedge clock);
        seq_sel    <= seq_sel_t'(s);
        level      <= lvl;
        write_mode <= wm;
        start      <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_turn();
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!your_turn && n < 200);
        expect_true(your_turn, "your_turn did not rise in time");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (playing && n < 400);
        expect_true(!playing, "game did not return to idle in time");
    endtask

    // follows the leds until the player's turn, one lit stretch per step
    task automatic watch_preview(input int s, input int len);
        int   n, k, lit_run, dark_run;
        logic done, clipped;
        n        = 0;
        k        = 0;
        lit_run  = 0;
        dark_run = 0;
        done     = 1'b0;
        clipped  = 1'b0;
        while (!done) begin
            @(negedge clock);
            n++;
            if (your_turn || n > 200) begin
                done = 1'b1;
            end else if (leds != '0) begin
                if (lit_run == 0) begin
                    if (n == 1) clipped = 1'b1;     // watch began mid step
                    if (k > 0) expect_eq("gap cycles", dark_run, `PLAYSEQ_GAP_CYCLES);
                    k++;
                    expect_true(k <= len, "preview shows more steps than the round length");
                end
                if (k <= len) expect_eq("leds", int'(leds), int'(exp_step(s, k - 1)));
                lit_run++;
                dark_run = 0;
            end else begin
                if (lit_run > 0) begin
                    if (k == 1 && clipped)
                        expect_true(lit_run <= `PLAYSEQ_SHOW_CYCLES, "first step lit too long");
                    else
                        expect_eq("show cycles", lit_run, `PLAYSEQ_SHOW_CYCLES);
                end
                lit_run = 0;
                dark_run++;
            end
        end
        expect_true(your_turn, "preview never handed over to the player");
        expect_eq("preview steps", k, len);
    endtask

    // plays every round correctly up to the full length
    task automatic play_game(input int s, input level_t lvl);
        int len;
        len = start_len(lvl);
        start_game(s, lvl, 1'b0);
        while (len <= `PLAYSEQ_SEQ_LEN) begin
            watch_preview(s, len);
            for (int i = 0; i < len; i++) begin
                wait_turn();
                press(exp_step(s, i));
            end
            len++;
        end
        wait_idle();
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        int err0;
        err0 = errors;
        @(negedge clock);
        expect_eq("leds", int'(leds), 0);
        expect_eq("wins", int'(wins), 0);
        expect_eq("losses", int'(losses), 0);
        expect_true(!your_turn, "your_turn high after reset");
        expect_true(!playing, "playing high after reset");
        report("reset", err0);
    endtask

    task automatic test_preview();
        int err0;
        err0 = errors;
        start_game(1, 2'd0, 1'b0);
        watch_preview(1, start_len(2'd0));
        wait_idle();                        // no presses, ends on timeout
        exp_losses++;
        expect_eq("losses", int'(losses), exp_losses);
        report("preview", err0);
    endtask

    task automatic test_full_win();
        int     err0;
        level_t lvl;
        err0 = errors;
        lvl  = level_t'($urandom_range(3, 0));
        play_game(0, lvl);
        exp_wins++;
        expect_eq("wins", int'(wins), exp_wins);
        expect_eq("losses", int'(losses), exp_losses);
        expect_true(!playing, "playing still high after the win");
        report("full_win", err0);
    endtask

    task automatic test_wrong_button();
        int     err0, r;
        level_t lvl;
        step_t  wrong;
        err0 = errors;
        lvl  = level_t'($urandom_range(3, 0));
        start_game(2, lvl, 1'b0);
        watch_preview(2, start_len(lvl));
        wait_turn();
        press(exp_step(2, 0));
        wrong = exp_step(2, 1);
        r     = 1 + int'($urandom_range(2, 0));
        repeat (r) wrong = {wrong[2:0], wrong[3]};  // one-hot rotate, never equal
        wait_turn();
        press(wrong);
        wait_idle();
        exp_losses++;
        expect_eq("losses", int'(losses), exp_losses);
        expect_eq("wins", int'(wins), exp_wins);
        report("wrong_button", err0);
    endtask

    task automatic test_timeout();
        int err0, n, limit;
        err0  = errors;
        limit = timeout_limit(2'd3);
        start_game(0, 2'd3, 1'b0);
        watch_preview(0, start_len(2'd3));
        n = 0;
        while (int'(losses) == exp_losses && n < limit + 20) begin
            @(negedge clock);
            n++;
        end
        exp_losses++;
        expect_eq("losses", int'(losses), exp_losses);
        expect_true(n >= limit, "loss came before the time limit");
        expect_true(n <= limit + 8, "no loss within the time limit plus margin");
        wait_idle();
        report("timeout", err0);
    endtask

    task automatic test_custom();
        int err0;
        err0 = errors;
        start_game(3, 2'd1, 1'b1);
        @(negedge clock);
        expect_true(!playing, "write mode started a game instead of sequence entry");
        for (int i = 0; i < `PLAYSEQ_SEQ_LEN; i++)
            press(exp_step(3, i));
        play_game(3, 2'd1);
        exp_wins++;
        expect_eq("wins", int'(wins), exp_wins);
        expect_eq("losses", int'(losses), exp_losses);
        report("custom", err0);
    endtask

    initial begin
        void'($urandom(32'h259b6ac3));
        custom_seq = '{4'h8, 4'h8, 4'h1, 4'h2, 4'h4, 4'h1, 4'h8, 4'h2};
        reset      <= 1'b1;
        start      <= 1'b0;
        level      <= '0;
        seq_sel    <= '0;
        write_mode <= 1'b0;
        buttons    <= '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        test_reset();
        test_preview();
        test_full_win();
        test_wrong_button();
        test_timeout();
        test_custom();

        $display("checks run: %0d, failed: %0d", checks, errors);
        if (errors == 0) $display("TEST PASS");
        else             $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/playseq_pkg.sv
hw/playseq_ctrl_if.sv
hw/playseq_input.sv
hw/playseq_datapath.sv
hw/playseq_control.sv
hw/playseq_output.sv
hw/playseq_top.sv
bench/tb_playseq.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the PlaySeq testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_playseq -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_playseq | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi
exit 0
